/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module eeprom_tb -o eeprom_sim &&
./obj_dir/eeprom_sim | tee /dev/stderr | grep -qxF '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb/eeprom_slave_model.sv */
`timescale 1ns/10ps

module eeprom_slave_model
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda,
    output logic        sda_pull,       // slave pulls the line low
    output logic [15:0] start_cnt,
    output logic [15:0] stop_cnt,
    output logic [15:0] ctrl_cnt,
    output logic [15:0] err_cnt,
    output logic [7:0]  last_wr_ctrl,
    output logic [7:0]  last_rd_ctrl
);

    import eeprom_pkg::*;

    localparam int PH_CTRL  = 0;
    localparam int PH_ADDR  = 1;
    localparam int PH_DATA  = 2;
    localparam int PH_EXTRA = 3;    // write data taken so only stop or restart may follow
    localparam int PH_TX    = 4;
    localparam int PH_IDLE  = 5;

    logic [7:0] mem [0:(1 << ADDR_W) - 1];
    logic       prev_scl;
    logic       prev_sda;
    logic       got_rise;
    logic       pend_bit;
    logic       tx_first;
    logic       have_addr;
    logic [3:0] bitcnt;
    logic [7:0] rx_sr;
    logic [7:0] tx_sr;
    logic [7:0] addr_lo;
    logic [2:0] blk;
    int         phase;
    logic [7:0] rx_full;

    initial
    begin
        for (int i = 0; i < (1 << ADDR_W); i++)
            mem[i] = i[7:0] ^ {i[10:8], 5'd0} ^ 8'h5a;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            prev_scl     <= 1'b1;
            prev_sda     <= 1'b1;
            got_rise     <= 1'b0;
            pend_bit     <= 1'b1;
            tx_first     <= 1'b0;
            have_addr    <= 1'b0;
            bitcnt       <= 4'd0;
            rx_sr        <= 8'h00;
            tx_sr        <= 8'hff;
            addr_lo      <= 8'h00;
            blk          <= 3'd0;
            phase        <= PH_IDLE;
            sda_pull     <= 1'b0;
            start_cnt    <= 16'd0;
            stop_cnt     <= 16'd0;
            ctrl_cnt     <= 16'd0;
            err_cnt      <= 16'd0;
            last_wr_ctrl <= 8'h00;
            last_rd_ctrl <= 8'h00;
        end
        else
        begin
            prev_scl <= scl;
            prev_sda <= sda;
            rx_full  = {rx_sr[6:0], pend_bit};

            if (prev_scl && scl && prev_sda && !sda)
            begin
                // start or repeated start
                start_cnt <= start_cnt + 16'd1;
                if (phase == PH_TX || bitcnt != 4'd0)
                    err_cnt <= err_cnt + 16'd1;
                phase    <= PH_CTRL;
                bitcnt   <= 4'd0;
                got_rise <= 1'b0;
                tx_first <= 1'b0;
                sda_pull <= 1'b0;
            end
            else if (prev_scl && scl && !prev_sda && sda)
            begin
                stop_cnt <= stop_cnt + 16'd1;
                if ((phase != PH_EXTRA && phase != PH_IDLE) || bitcnt != 4'd0)
                    err_cnt <= err_cnt + 16'd1;    // stop in the middle of a transfer
                phase     <= PH_IDLE;
                have_addr <= 1'b0;
                got_rise  <= 1'b0;
                sda_pull  <= 1'b0;
            end
            else if (!prev_scl && scl)
            begin
                got_rise <= 1'b1;
                pend_bit <= sda;
            end
            else if (prev_scl && !scl && got_rise)
            begin
                got_rise <= 1'b0;
                if (phase == PH_IDLE)
                begin
                    // clocks outside a transfer are ignored
                end
                else if (bitcnt < 4'd8)
                begin
                    rx_sr  <= rx_full;
                    bitcnt <= bitcnt + 4'd1;
                    if (phase == PH_TX)
                    begin
                        if (bitcnt == 4'd7)
                            sda_pull <= 1'b0;    // master ack slot
                        else
                        begin
                            sda_pull <= ~tx_sr[7];
                            tx_sr    <= {tx_sr[6:0], 1'b0};
                        end
                    end
                    else if (bitcnt == 4'd7)
                    begin
                        sda_pull <= 1'b1;    // ack every byte received
                        case (phase)
                            PH_CTRL:
                            begin
                                ctrl_cnt <= ctrl_cnt + 16'd1;
                                if (rx_full[7:4] != DEV_TYPE)
                                begin
                                    err_cnt  <= err_cnt + 16'd1;
                                    sda_pull <= 1'b0;
                                    phase    <= PH_IDLE;
                                end
                                else if (rx_full[0])
                                begin
                                    last_rd_ctrl <= rx_full;
                                    if (!have_addr)
                                        err_cnt <= err_cnt + 16'd1;
                                    tx_sr    <= mem[{rx_full[3:1], addr_lo}];
                                    tx_first <= 1'b1;
                                    phase    <= PH_TX;
                                end
                                else
                                begin
                                    last_wr_ctrl <= rx_full;
                                    blk          <= rx_full[3:1];
                                    phase        <= PH_ADDR;
                                end
                            end
                            PH_ADDR:
                            begin
                                addr_lo   <= rx_full;
                                have_addr <= 1'b1;
                                phase     <= PH_DATA;
                            end
                            PH_DATA:
                            begin
                                mem[{blk, addr_lo}] <= rx_full;
                                phase               <= PH_EXTRA;
                            end
                            default:
                            begin
                                err_cnt <= err_cnt + 16'd1;    // page writes not supported
                            end
                        endcase
                    end
                end
                else
                begin
                    // end of the ack slot
                    bitcnt   <= 4'd0;
                    sda_pull <= 1'b0;
                    if (phase == PH_TX)
                    begin
                        if (tx_first)
                        begin
                            sda_pull <= ~tx_sr[7];
                            tx_sr    <= {tx_sr[6:0], 1'b0};
                            tx_first <= 1'b0;
                        end
                        else
                        begin
                            if (!pend_bit)
                                err_cnt <= err_cnt + 16'd1;    // single byte read must end in nack
                            phase <= PH_IDLE;
                        end
                    end
                end
            end
        end
    end

endmodule

/* tb/eeprom_tb.sv */
`timescale 1ns/10ps

module eeprom_tb;

    import eeprom_pkg::*;

    localparam int ACK_TIMEOUT = 4000;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic [7:0]        rdata;
    logic              ack;
    logic              busy;
    logic              scl;
    logic              sda_oe;
    logic              sda_in;
    logic              sda;
    logic              slave_pull;
    logic [15:0]       start_cnt;
    logic [15:0]       stop_cnt;
    logic [15:0]       ctrl_cnt;
    logic [15:0]       err_cnt;
    logic [7:0]        last_wr_ctrl;
    logic [7:0]        last_rd_ctrl;

    logic [7:0]        ref_mem [0:(1 << ADDR_W) - 1];
    logic [31:0]       seed;
    int                errors;
    int                txns;
    logic              timed_out;
    logic [ADDR_W-1:0] a;
    logic [7:0]        d;

    assign sda    = ~(sda_oe | slave_pull);    // wired-AND with a pull-up
    assign sda_in = sda;

    eeprom_if_top #(.QUARTER_CYCLES(2)) dut_i
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .ack    (ack),
        .busy   (busy),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    eeprom_slave_model slave_i
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .scl          (scl),
        .sda          (sda),
        .sda_pull     (slave_pull),
        .start_cnt    (start_cnt),
        .stop_cnt     (stop_cnt),
        .ctrl_cnt     (ctrl_cnt),
        .err_cnt      (err_cnt),
        .last_wr_ctrl (last_wr_ctrl),
        .last_rd_ctrl (last_rd_ctrl)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one host request with an optional second request while busy
    task automatic run_txn(input logic do_wr, input logic do_rd, input logic [ADDR_W-1:0] ta,
                           input logic [7:0] td, input logic poke);
        logic [15:0] starts0;
        logic [15:0] stops0;
        logic [15:0] ctrls0;
        logic [7:0]  exp_wctrl;
        logic [7:0]  exp_rctrl;
        logic        seen;
        int          cycles;
        if (timed_out)
            return;
        exp_wctrl = {4'b1010, ta[10:8], 1'b0};
        exp_rctrl = {4'b1010, ta[10:8], 1'b1};
        starts0   = start_cnt;
        stops0    = stop_cnt;
        ctrls0    = ctrl_cnt;
        txns++;
        @(negedge CLK);
        wr    = do_wr;
        rd    = do_rd;
        addr  = ta;
        wdata = td;
        @(negedge CLK);
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = ~ta;    // operands must already be latched
        wdata = ~td;
        if (busy !== 1'b1)
        begin
            $display("[FAIL] busy: got %h, expected 1", busy);
            errors++;
        end
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
            wr = poke && (cycles == 20);
            rd = poke && (cycles == 20);
            if (ack === 1'b1)
                seen = 1'b1;
        end
        wr = 1'b0;
        rd = 1'b0;
        if (!seen)
        begin
            $display("timeout waiting for ack, sequencer stuck in %s",
                     dut_i.ctrl_i.state.name());
            errors++;
            timed_out = 1'b1;
            return;
        end
        if (busy !== 1'b0)
        begin
            $display("[FAIL] busy at ack: got %h, expected 0", busy);
            errors++;
        end
        if (do_wr)
            ref_mem[ta] = td;
        else if (rdata !== ref_mem[ta])
        begin
            $display("[FAIL] rdata at addr %h: got %h, expected %h", ta, rdata, ref_mem[ta]);
            errors++;
        end
        @(negedge CLK);
        if (ack !== 1'b0)
        begin
            $display("[FAIL] ack second cycle: got %h, expected 0", ack);
            errors++;
        end
        if (stop_cnt - stops0 !== 16'd1)
        begin
            $display("[FAIL] stop count: got %h, expected 1", stop_cnt - stops0);
            errors++;
        end
        if (start_cnt - starts0 !== (do_wr ? 16'd1 : 16'd2))
        begin
            $display("[FAIL] start count: got %h, expected %h", start_cnt - starts0,
                     do_wr ? 16'd1 : 16'd2);
            errors++;
        end
        if (ctrl_cnt - ctrls0 !== (do_wr ? 16'd1 : 16'd2))
        begin
            $display("[FAIL] control byte count: got %h, expected %h", ctrl_cnt - ctrls0,
                     do_wr ? 16'd1 : 16'd2);
            errors++;
        end
        if (last_wr_ctrl !== exp_wctrl)
        begin
            $display("[FAIL] write control byte: got %h, expected %h", last_wr_ctrl, exp_wctrl);
            errors++;
        end
        if (!do_wr && last_rd_ctrl !== exp_rctrl)
        begin
            $display("[FAIL] read control byte: got %h, expected %h", last_rd_ctrl, exp_rctrl);
            errors++;
        end
        if (err_cnt !== 16'd0)
        begin
            $display("slave model flagged %0d protocol errors", err_cnt);
            errors++;
        end
    endtask

    // no stray ack or busy after an ignored request
    task automatic expect_quiet(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge CLK);
            if (ack !== 1'b0 || busy !== 1'b0)
            begin
                $display("unexpected ack or busy after a request made while busy");
                errors++;
                break;
            end
        end
    endtask

    initial
    begin
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = 8'h00;
        RESET     = 1'b1;
        errors    = 0;
        txns      = 0;
        timed_out = 1'b0;
        seed      = 32'h66f6_4d2e;
        for (int i = 0; i < (1 << ADDR_W); i++)
            ref_mem[i] = i[7:0] ^ {i[10:8], 5'd0} ^ 8'h5a;

        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        if (scl !== 1'b1 || sda_oe !== 1'b0 || ack !== 1'b0 || busy !== 1'b0)
        begin
            $display("[FAIL] after reset scl=%h sda_oe=%h ack=%h busy=%h", scl, sda_oe, ack, busy);
            errors++;
        end

        // write then read back
        seed = xorshift32(seed);
        a    = seed[ADDR_W-1:0];
        d    = seed[23:16];
        run_txn(1'b1, 1'b0, a, d, 1'b0);
        run_txn(1'b0, 1'b1, a, d, 1'b0);

        repeat (200)
        begin
            seed = xorshift32(seed);
            a    = seed[ADDR_W-1:0];
            d    = seed[19:12];
            if (seed[31])
                run_txn(1'b1, 1'b0, a, d, 1'b0);
            else
                run_txn(1'b0, 1'b1, a, d, 1'b0);
        end

        // requests during busy go nowhere
        seed = xorshift32(seed);
        a    = seed[ADDR_W-1:0];
        d    = seed[7:0];
        run_txn(1'b1, 1'b0, a, d, 1'b1);
        expect_quiet(400);
        run_txn(1'b0, 1'b1, ~a, 8'h00, 1'b1);
        expect_quiet(400);
        run_txn(1'b0, 1'b1, a, 8'h00, 1'b0);

        // wr and rd together is a write
        seed = xorshift32(seed);
        a    = seed[ADDR_W-1:0];
        d    = seed[15:8];
        run_txn(1'b1, 1'b1, a, d, 1'b0);
        run_txn(1'b0, 1'b1, a, 8'h00, 1'b0);

        $display("%0d transactions, %0d errors, %0d slave protocol errors",
                 txns, errors, err_cnt);
        if (errors == 0 && err_cnt == 16'd0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
verilog/eeprom_pkg.sv
verilog/eeprom_bit_engine.sv
verilog/eeprom_rw_ctrl.sv
verilog/eeprom_if_top.sv
tb/eeprom_slave_model.sv
tb/eeprom_tb.sv

/* verilog/eeprom_bit_engine.sv */
`timescale 1ns/10ps

module eeprom_bit_engine
#(
    parameter int QUARTER_CYCLES = 2
)
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  eeprom_pkg::bus_op_t  op,
    input  logic                 op_go,
    input  logic [7:0]           tx_byte,
    input  logic                 nack_last,
    output logic                 op_done,
    output logic [7:0]           rx_byte,
    output logic                 engine_idle,
    output logic                 scl,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    import eeprom_pkg::*;

    localparam int QW = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

    logic          active;
    bus_op_t       op_r;
    logic          nack_r;
    logic [QW-1:0] qcnt;      // clocks within a quarter
    logic [1:0]    phase;     // quarter within a bit slot
    logic [3:0]    slot;      // bit slot, 8 is the ack slot
    logic [7:0]    shreg;
    logic          qend;
    logic          last_quarter;

    // values for the quarter about to start
    bus_op_t       cur_op;
    logic          cur_nack;
    logic [7:0]    src;
    logic [1:0]    nphase;
    logic [3:0]    nslot;
    logic          scl_nxt;
    logic          sda_oe_nxt;

    assign qend = (qcnt == QW'(QUARTER_CYCLES - 1));

    always_comb
    begin
        if (op_r == OP_START || op_r == OP_STOP)
            last_quarter = (phase == 2'd3) && (slot == 4'd0);
        else
            last_quarter = (phase == 2'd3) && (slot == 4'd8);
    end

    always_comb
    begin
        if (active)
        begin
            cur_op   = op_r;
            cur_nack = nack_r;
            src      = shreg;
            nphase   = phase + 2'd1;
            nslot    = (phase == 2'd3) ? slot + 4'd1 : slot;
        end
        else
        begin
            // first quarter of a fresh op
            cur_op   = op;
            cur_nack = nack_last;
            src      = tx_byte;
            nphase   = 2'd0;
            nslot    = 4'd0;
        end

        // q0 low, q1 rise, q2 high, q3 fall
        scl_nxt = (nphase == 2'd1) || (nphase == 2'd2);

        case (cur_op)
            OP_START:
            begin
                sda_oe_nxt = (nphase >= 2'd2);     // pull low mid-high
            end
            OP_STOP:
            begin
                scl_nxt    = (nphase != 2'd0);     // bus left idle high
                sda_oe_nxt = (nphase < 2'd2);      // release mid-high
            end
            OP_BYTE_OUT:
            begin
                if (nslot < 4'd8)
                    sda_oe_nxt = ~src[~nslot[2:0]];    // msb first
                else
                    sda_oe_nxt = 1'b0;                 // slave ack
            end
            default:
            begin
                if (nslot == 4'd8)
                    sda_oe_nxt = ~cur_nack;
                else
                    sda_oe_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            op_r   <= OP_STOP;
            nack_r <= 1'b0;
            qcnt   <= '0;
            phase  <= 2'd0;
            slot   <= 4'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end
        else if (!active)
        begin
            if (op_go)
            begin
                active <= 1'b1;
                op_r   <= op;
                nack_r <= nack_last;
                qcnt   <= '0;
                phase  <= 2'd0;
                slot   <= 4'd0;
                scl    <= scl_nxt;
                sda_oe <= sda_oe_nxt;
            end
        end
        else if (qend)
        begin
            qcnt <= '0;
            if (last_quarter)
            begin
                active <= 1'b0;    // scl and sda hold their last level
            end
            else
            begin
                phase  <= nphase;
                slot   <= nslot;
                scl    <= scl_nxt;
                sda_oe <= sda_oe_nxt;
            end
        end
        else
        begin
            qcnt <= qcnt + QW'(1);
        end
    end

    // tx byte held for output, rx bits shifted in at end of high quarter
    always_ff @(posedge CLK)
    begin
        if (op_go && !active)
            shreg <= tx_byte;
        else if (active && op_r == OP_BYTE_IN && phase == 2'd2 && qend && slot < 4'd8)
            shreg <= {shreg[6:0], sda_in};
    end

    assign rx_byte     = shreg;
    assign op_done     = active && qend && last_quarter;
    assign engine_idle = ~active;

endmodule

/* verilog/eeprom_if_top.sv */
`timescale 1ns/10ps

module eeprom_if_top
#(
    parameter int QUARTER_CYCLES = 2    // clk cycles per quarter scl period
)
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          busy,
    output logic                          scl,
    output logic                          sda_oe,
    input  logic                          sda_in
);

    import eeprom_pkg::*;

    bus_op_t    op;
    logic       op_go;
    logic [7:0] tx_byte;
    logic       nack_last;
    logic       op_done;
    logic [7:0] rx_byte;
    logic       engine_idle;

    eeprom_rw_ctrl ctrl_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .ack         (ack),
        .busy        (busy),
        .op          (op),
        .op_go       (op_go),
        .tx_byte     (tx_byte),
        .nack_last   (nack_last),
        .op_done     (op_done),
        .rx_byte     (rx_byte),
        .engine_idle (engine_idle)
    );

    eeprom_bit_engine
    #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    )
    engine_i
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .op          (op),
        .op_go       (op_go),
        .tx_byte     (tx_byte),
        .nack_last   (nack_last),
        .op_done     (op_done),
        .rx_byte     (rx_byte),
        .engine_idle (engine_idle),
        .scl         (scl),
        .sda_oe      (sda_oe),
        .sda_in      (sda_in)
    );

endmodule

/* verilog/eeprom_pkg.sv */
package eeprom_pkg;

    // byte address width, 2 K bytes
    localparam int ADDR_W = 11;

    // upper nibble of every control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // sequencer states
    typedef enum logic [3:0]
    {
        IDLE,
        WR_START,
        WR_CTRL,
        WR_ADDR,
        WR_DATA,
        RD_RESTART,    // repeated start before the read control byte
        RD_CTRL,
        RD_DATA,
        STOP,
        DONE
    } ctrl_state_t;

    // operations run by the bit engine
    typedef enum logic [1:0]
    {
        OP_START,      // sda falls while scl high
        OP_STOP,       // sda rises while scl high
        OP_BYTE_OUT,   // 8 bits out, slave ack slot
        OP_BYTE_IN     // 8 bits in, master ack/nack slot
    } bus_op_t;

endpackage

/* verilog/eeprom_rw_ctrl.sv */
`timescale 1ns/10ps

module eeprom_rw_ctrl
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata,
    output logic                          ack,
    output logic                          busy,
    output eeprom_pkg::bus_op_t           op,
    output logic                          op_go,
    output logic [7:0]                    tx_byte,
    output logic                          nack_last,
    input  logic                          op_done,
    input  logic [7:0]                    rx_byte,
    input  logic                          engine_idle
);

    import eeprom_pkg::*;

    ctrl_state_t       state;
    logic              issued;    // op_go sent for this state
    logic              is_rd;
    logic [ADDR_W-1:0] addr_r;
    logic [7:0]        wdata_r;

    always_comb
    begin
        case (state)
            WR_START,
            RD_RESTART: op = OP_START;
            WR_CTRL,
            WR_ADDR,
            WR_DATA,
            RD_CTRL:    op = OP_BYTE_OUT;
            RD_DATA:    op = OP_BYTE_IN;
            default:    op = OP_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            WR_CTRL: tx_byte = {DEV_TYPE, addr_r[10:8], 1'b0};
            WR_ADDR: tx_byte = addr_r[7:0];
            WR_DATA: tx_byte = wdata_r;
            RD_CTRL: tx_byte = {DEV_TYPE, addr_r[10:8], 1'b1};
            default: tx_byte = 8'hff;
        endcase
    end

    assign nack_last = (state == RD_DATA);    // single byte read ends in nack

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= IDLE;
            issued <= 1'b0;
            op_go  <= 1'b0;
            ack    <= 1'b0;
            busy   <= 1'b0;
            is_rd  <= 1'b0;
            rdata  <= 8'h00;
        end
        else
        begin
            op_go <= 1'b0;
            ack   <= 1'b0;

            if (state != IDLE && state != DONE && !issued && engine_idle)
            begin
                op_go  <= 1'b1;
                issued <= 1'b1;
            end

            case (state)
                IDLE:
                begin
                    if (wr || rd)
                    begin
                        is_rd  <= !wr;    // write wins
                        busy   <= 1'b1;
                        issued <= 1'b0;
                        state  <= WR_START;
                    end
                end
                WR_START:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= WR_CTRL;
                    end
                end
                WR_CTRL:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= WR_ADDR;
                    end
                end
                WR_ADDR:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= is_rd ? RD_RESTART : WR_DATA;
                    end
                end
                WR_DATA,
                RD_DATA:
                begin
                    if (op_done)
                    begin
                        if (state == RD_DATA)
                            rdata <= rx_byte;
                        issued <= 1'b0;
                        state  <= STOP;
                    end
                end
                RD_RESTART:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= RD_CTRL;
                    end
                end
                RD_CTRL:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= RD_DATA;
                    end
                end
                STOP:
                begin
                    if (op_done)
                    begin
                        issued <= 1'b0;
                        state  <= DONE;
                    end
                end
                default:
                begin
                    ack   <= 1'b1;    // busy drops in the same cycle
                    busy  <= 1'b0;
                    state <= IDLE;
                end
            endcase
        end
    end

    // operands captured at accept
    always_ff @(posedge CLK)
    begin
        if (state == IDLE && (wr || rd))
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
    end

endmodule
